// File: src.f
+incdir+hdl
+incdir+tests
hdl/fpu_pkg.sv
hdl/delay_pipe.sv
hdl/fpu_issue_stage.sv
hdl/fpu_sign_unit.sv
hdl/int_fused_unit.sv
hdl/fpu_result_stage.sv
hdl/fpu64.sv
tests/tb_fpu64.sv

// File: Bender.yml
package:
  name: fpu64

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fpu_pkg.sv
      - hdl/delay_pipe.sv
      - hdl/fpu_issue_stage.sv
      - hdl/fpu_sign_unit.sv
      - hdl/int_fused_unit.sv
      - hdl/fpu_result_stage.sv
      - hdl/fpu64.sv
  - target: test
    include_dirs:
      - hdl
      - tests
    files:
      - tests/tb_fpu64.sv

// File: tests/fpu64_model.svh
`ifndef FPU64_MODEL_SVH
`define FPU64_MODEL_SVH

// Reference model of the execution unit

// Sign injection and FSIGN on raw double words
function automatic logic [`FPU_WID-1:0] sign_op_result(flt_func_t fn, logic [`FPU_WID-1:0] a,
	logic [`FPU_WID-1:0] b);
	logic [`FPU_WID-1:0] one;
	logic a_special;
	one = `FPU_ONE;
	// Zero of either sign or any NaN
	a_special = (a[62:0] == '0) || ((a[62:52] == `FPU_EXP_MAX) && (a[51:0] != '0));
	case (fn)
		FLT_SGNJ:  return {a[63], b[62:0]};
		FLT_SGNJN: return {~a[63], b[62:0]};
		FLT_SGNJX: return {a[63] ^ b[63], b[62:0]};
		FLT_SIGN:  return a_special ? a : {a[63], one[62:0]};
		default:   return '0;
	endcase
endfunction

// Status flags of a float result
function automatic fp_status_t float_status(logic [`FPU_WID-1:0] w, logic [`FPU_RM_WID-1:0] rm);
	fp_status_t st;
	logic mag_zero;
	logic exp_ones;
	mag_zero = (w[62:0] == '0);
	exp_ones = (w[62:52] == `FPU_EXP_MAX);
	st.rm = rm;
	st.cls = ((w[62:52] == '0) && !mag_zero) || (w[63] && mag_zero) || (exp_ones && w[51]);
	st.neg = w[63] && !mag_zero;
	st.pos = !w[63] && !mag_zero;
	st.zero = mag_zero;
	st.inf = exp_ones && (w[51:0] == '0);
	return st;
endfunction

// Immediate, fused R3 and LOADA
function automatic logic [`FPU_WID-1:0] int_op_result(opcode_t opc, r3_func_t fn, logic [2:0] op3,
	logic [1:0] scale, logic [`FPU_WID-1:0] a, logic [`FPU_WID-1:0] b,
	logic [`FPU_WID-1:0] c, logic [`FPU_WID-1:0] i);
	logic [`FPU_WID-1:0] r;
	logic [`FPU_WID-1:0] f;
	r = (fn == FN_ADD) ? a + b : (fn == FN_AND) ? a & b : (fn == FN_OR) ? a | b : a ^ b;
	case (op3)
		3'd0: f = r & c;
		3'd1: f = r | c;
		3'd2: f = r ^ c;
		3'd3: f = r + c;
		3'd4: f = r << c;
		3'd6: f = (c != '0) ? r : '0;
		3'd7: f = (c != '0) ? r : b;
		default: f = '0;
	endcase
	case (opc)
		OP_ADDI:  return a + i;
		OP_SUBFI: return i - a;
		OP_ANDI:  return a & i;
		OP_ORI:   return a | i;
		OP_XORI:  return a ^ i;
		OP_R3:    return f;
		OP_LOADA: return a + i + (b << scale);
		default:  return '0;
	endcase
endfunction

`endif

// File: tests/tb_fpu64.sv
`timescale 1ns/1ns
`default_nettype none

`include "fpu_consts.svh"

module tb_fpu64 import fpu_pkg::*; ();

	localparam int N_OPS = 600;
	localparam int MAX_CYCLES = N_OPS * 4 / 3 + 200;  // 3/4 issue rate plus drain

	typedef struct packed {
		logic [31:0]         issue_cycle;
		logic [`FPU_WID-1:0] o;
		fp_status_t          sto;
		logic                ust;
	} expect_t;

	logic clk;
	logic rst;
	logic issue;
	opcode_t opcode;
	r3_func_t r3_func;
	logic [2:0] op3;
	flt_func_t flt_func;
	logic [`FPU_SCALE_WID-1:0] scale;
	logic rc;
	logic [`FPU_WID-1:0] a;
	logic [`FPU_WID-1:0] b;
	logic [`FPU_WID-1:0] c;
	logic [`FPU_WID-1:0] t;
	logic [`FPU_WID-1:0] i;
	fp_status_t s;
	logic [`FPU_WID-1:0] o;
	fp_status_t sto;
	logic ust;
	logic done;

	expect_t exp_q[$];
	logic [31:0] rng_state;
	int unsigned edge_cnt = 0;
	int unsigned run_cycles = 0;
	int unsigned value_errs = 0;
	int unsigned timing_errs = 0;
	int unsigned n_issued = 0;
	logic [4:0] r3_idx = '0;  // Walks all func/op3 pairs

	`include "fpu64_model.svh"

	fpu64 u_fpu64 (
		.clk(clk), .rst(rst), .issue(issue),
		.opcode(opcode), .r3_func(r3_func), .op3(op3), .flt_func(flt_func),
		.scale(scale), .rc(rc), .a(a), .b(b), .c(c), .t(t), .i(i), .s(s),
		.o(o), .sto(sto), .ust(ust), .done(done)
	);

	initial
		clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	// Watchdog
	always @(posedge clk)
	begin
		if (!rst)
		begin
			run_cycles <= run_cycles + 1;
			if (run_cycles >= MAX_CYCLES)
			begin
				$display("Timeout after %0d cycles with %0d results outstanding",
					run_cycles, exp_q.size());
				$display("Test failures found");
				$finish;
			end
		end
	end

	function logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Random word biased towards special values
	function automatic logic [`FPU_WID-1:0] pick_operand();
		logic [31:0] sel;
		logic [`FPU_WID-1:0] r;
		sel = next_rand();
		r = {next_rand(), next_rand()};
		case (sel[3:0])
			4'd0: return '0;
			4'd1: return {1'b1, 63'h0};                                   // -0
			4'd2: return {r[63], `FPU_EXP_MAX, 52'h0};                    // Infinity
			4'd3: return {r[63], `FPU_EXP_MAX, 1'b1, r[50:0]};            // Quiet NaN
			4'd4: return {r[63], `FPU_EXP_MAX, 1'b0, r[50:1], 1'b1};      // Signalling NaN
			4'd5: return {r[63], 11'h0, r[51:1], 1'b1};                   // Denormal
			4'd6: return {56'h0, r[7:0]};
			default: return r;
		endcase
	endfunction

	task verify_reset_outputs();
		assert (done === 1'b0 && ust === 1'b0 && sto === '0)
		else
		begin
			$display("FAILED at %0t ns: outputs not cleared in reset", $time);
			value_errs++;
		end
	endtask

	// ==============================
	// Output checks once per cycle
	// ==============================
	task compare_outputs();
		expect_t e;
		logic exp_done;
		exp_done = (exp_q.size() > 0) && (exp_q[0].issue_cycle + `FPU_LATENCY == edge_cnt);
		assert (done === exp_done)
		else
		begin
			if (exp_done)
				$display("Error at %0t ns: no done for the op issued in cycle %0d", $time,
					exp_q[0].issue_cycle);
			else
				$display("Error at %0t ns: done pulsed with no result due", $time);
			timing_errs++;
		end
		if (exp_done)
		begin
			e = exp_q.pop_front();
			if (done === 1'b1)
			begin
				assert (o === e.o)
				else
				begin
					$display("FAILED at %0t ns: o = %h, expected %h", $time, o, e.o);
					value_errs++;
				end
				assert (sto === e.sto)
				else
				begin
					$display("FAILED at %0t ns: sto = %h, expected %h", $time, sto, e.sto);
					value_errs++;
				end
				assert (ust === e.ust)
				else
				begin
					$display("FAILED at %0t ns: ust = %b, expected %b", $time, ust, e.ust);
					value_errs++;
				end
			end
		end
	endtask

	// New op on about three cycles out of four
	task drive_op();
		logic [31:0] r;
		logic [31:0] r2;
		expect_t e;
		r = next_rand();
		r2 = next_rand();
		issue = (r[1:0] != 2'b00);
		opcode = opcode_t'(r[15:8] % 9);
		if (opcode == OP_R3)
		begin
			r3_func = r3_func_t'(r3_idx[4:3]);
			op3 = r3_idx[2:0];
		end
		else
		begin
			r3_func = r3_func_t'(r[17:16]);
			op3 = r[20:18];
		end
		flt_func = flt_func_t'(r[29:22] % 5);
		scale = r[31:30];
		rc = r[2];
		a = pick_operand();
		b = pick_operand();
		c = (r2[9:8] == 2'b00) ? '0 : pick_operand();  // Zero c for op3 6 and 7
		t = pick_operand();
		i = pick_operand();
		s = r2[7:0];
		if (issue)
		begin
			e.issue_cycle = edge_cnt;
			e.ust = rc;
			e.sto = s;
			if (opcode == OP_NOP)
				e.o = t;
			else if (opcode == OP_FLT && flt_func == FLT_RM)
			begin
				e.o = {{(`FPU_WID-`FPU_RM_WID){1'b0}}, s.rm};
				e.sto.rm = a[`FPU_RM_WID-1:0];
			end
			else if (opcode == OP_FLT)
			begin
				e.o = sign_op_result(flt_func, a, b);
				e.sto = float_status(e.o, s.rm);
			end
			else
				e.o = int_op_result(opcode, r3_func, op3, scale, a, b, c, i);
			exp_q.push_back(e);
			n_issued++;
			if (opcode == OP_R3)
				r3_idx = r3_idx + 1;
		end
	endtask

	initial
	begin
		rng_state = 32'h60b2;
		rst = 1'b1;
		issue = 1'b0;
		opcode = OP_NOP;
		r3_func = FN_ADD;
		op3 = '0;
		flt_func = FLT_SGNJ;
		scale = '0;
		rc = 1'b0;
		a = '0;
		b = '0;
		c = '0;
		t = '0;
		i = '0;
		s = '0;
		repeat (4)
		begin
			@(negedge clk);
			verify_reset_outputs();
		end
		rst = 1'b0;
		while (n_issued < N_OPS)
		begin
			@(negedge clk);
			compare_outputs();
			drive_op();
		end
		while (exp_q.size() > 0)
		begin
			@(negedge clk);
			compare_outputs();
			issue = 1'b0;
		end
		repeat (3)  // No stray done once drained
		begin
			@(negedge clk);
			compare_outputs();
		end
		$display("%0d ops checked, %0d value errors, %0d timing errors", n_issued,
			value_errs, timing_errs);
		if (value_errs + timing_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/fpu64.sv
`timescale 1ns/1ns
`default_nettype none

`include "fpu_consts.svh"

module fpu64 import fpu_pkg::*; (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       issue,
	input  opcode_t                   opcode,
	input  r3_func_t                  r3_func,
	input  wire [2:0]                 op3,
	input  flt_func_t                 flt_func,
	input  wire [`FPU_SCALE_WID-1:0]  scale,
	input  wire                       rc,
	input  wire [`FPU_WID-1:0]        a,
	input  wire [`FPU_WID-1:0]        b,
	input  wire [`FPU_WID-1:0]        c,
	input  wire [`FPU_WID-1:0]        t,
	input  wire [`FPU_WID-1:0]        i,
	input  fp_status_t                s,
	output logic [`FPU_WID-1:0]       o,
	output fp_status_t                sto,
	output logic                      ust,
	output logic                      done
);

	// Stage 1
	micro_op_t op_q;
	logic [`FPU_WID-1:0] a_q;
	logic [`FPU_WID-1:0] b_q;
	logic [`FPU_WID-1:0] c_q;
	logic [`FPU_WID-1:0] i_q;

	// Stage 2
	micro_op_t op_d2;
	logic [`FPU_WID-1:0] t_d2;
	fp_status_t s_d2;
	fp_word_t sign_res;
	logic [`FPU_WID-1:0] int_res;

	fpu_issue_stage u_issue (
		.clk(clk), .rst(rst), .issue(issue),
		.opcode(opcode), .r3_func(r3_func), .op3(op3), .flt_func(flt_func),
		.scale(scale), .rc(rc),
		.a(a), .b(b), .c(c), .t(t), .i(i), .s(s),
		.op_q(op_q), .a_q(a_q), .b_q(b_q), .c_q(c_q), .i_q(i_q),
		.op_d2(op_d2), .t_d2(t_d2), .s_d2(s_d2)
	);

	fpu_sign_unit u_sign (
		.clk(clk), .op_q(op_q), .a_q(a_q), .b_q(b_q), .sign_res(sign_res)
	);

	int_fused_unit u_int (
		.clk(clk), .op_q(op_q),
		.a_q(a_q), .b_q(b_q), .c_q(c_q), .i_q(i_q),
		.int_res(int_res)
	);

	fpu_result_stage u_result (
		.clk(clk), .rst(rst),
		.op_d2(op_d2), .t_d2(t_d2), .s_d2(s_d2),
		.sign_res(sign_res), .int_res(int_res),
		.o(o), .sto(sto), .ust(ust), .done(done)
	);

endmodule

`default_nettype wire

// File: hdl/fpu_result_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "fpu_consts.svh"

module fpu_result_stage import fpu_pkg::*; (
	input  wire                 clk,
	input  wire                 rst,
	input  micro_op_t           op_d2,
	input  wire [`FPU_WID-1:0]  t_d2,
	input  fp_status_t          s_d2,
	input  fp_word_t            sign_res,
	input  wire [`FPU_WID-1:0]  int_res,
	output logic [`FPU_WID-1:0] o,
	output fp_status_t          sto,
	output logic                ust,
	output logic                done
);

	logic [`FPU_WID-1:0] res;
	fp_status_t st;
	logic flt_op;
	logic sign_op;

	assign flt_op = (op_d2.opcode == OP_FLT);
	assign sign_op = flt_op && (op_d2.flt_func inside {FLT_SGNJ, FLT_SGNJN, FLT_SGNJX, FLT_SIGN});

	// ==============================
	// Result and status select
	// ==============================
	always_comb
	begin
		res = int_res;
		st = s_d2;
		case (op_d2.opcode)
			OP_FLT:
			begin
				if (op_d2.flt_func == FLT_RM)
				begin
					// Old mode out, new mode in
					res = {{(`FPU_WID-`FPU_RM_WID){1'b0}}, s_d2.rm};
					st.rm = op_d2.rm_src;
				end
				else
					res = sign_res;
				if (sign_op)
					st = fp_classify(sign_res, s_d2.rm);  // rm kept
			end
			OP_NOP:
				res = t_d2;  // Copy of target
			default:
				res = int_res;
		endcase
	end

	always_ff @(posedge clk)
		o <= res;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sto <= '0;
			ust <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			sto <= st;
			ust <= op_d2.issue & op_d2.rc;
			done <= op_d2.issue;
		end
	end

	// Sign flags of a computed status are exclusive
	a_neg_pos: assert property (@(posedge clk) disable iff (rst)
		op_d2.issue && sign_op |-> !(st.neg && st.pos));
	a_zero_excl: assert property (@(posedge clk) disable iff (rst)
		op_d2.issue && sign_op |-> !(st.zero && (st.neg || st.pos)));

endmodule

`default_nettype wire

// File: hdl/int_fused_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "fpu_consts.svh"

module int_fused_unit import fpu_pkg::*; (
	input  wire                 clk,
	input  micro_op_t           op_q,
	input  wire [`FPU_WID-1:0]  a_q,
	input  wire [`FPU_WID-1:0]  b_q,
	input  wire [`FPU_WID-1:0]  c_q,
	input  wire [`FPU_WID-1:0]  i_q,
	output logic [`FPU_WID-1:0] int_res
);

	logic [`FPU_WID-1:0] r;
	logic [`FPU_WID-1:0] fused;
	logic [`FPU_WID-1:0] res;
	logic c_set;

	assign c_set = |c_q;

	// ==============================
	// Fused R3, first then second op
	// ==============================
	always_comb
	begin
		case (op_q.r3_func)
			FN_ADD: r = a_q + b_q;
			FN_AND: r = a_q & b_q;
			FN_OR:  r = a_q | b_q;
			default: r = a_q ^ b_q;  // FN_XOR
		endcase
	end

	always_comb
	begin
		case (op_q.op3)
			3'd0: fused = r & c_q;
			3'd1: fused = r | c_q;
			3'd2: fused = r ^ c_q;
			3'd3: fused = r + c_q;
			3'd4: fused = r << c_q;
			3'd6: fused = c_set ? r : '0;  // Target not held here
			3'd7: fused = c_set ? r : b_q;
			default: fused = '0;
		endcase
	end

	// Result by opcode
	always_comb
	begin
		case (op_q.opcode)
			OP_ADDI:  res = a_q + i_q;
			OP_SUBFI: res = i_q - a_q;
			OP_ANDI:  res = a_q & i_q;
			OP_ORI:   res = a_q | i_q;
			OP_XORI:  res = a_q ^ i_q;
			OP_R3:    res = fused;
			OP_LOADA: res = a_q + i_q + (b_q << op_q.scale);  // Scaled index
			default:  res = '0;
		endcase
	end

	always_ff @(posedge clk)
		int_res <= res;

endmodule

`default_nettype wire

// File: hdl/fpu_sign_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "fpu_consts.svh"

module fpu_sign_unit import fpu_pkg::*; (
	input  wire                 clk,
	input  micro_op_t           op_q,
	input  wire [`FPU_WID-1:0]  a_q,
	input  wire [`FPU_WID-1:0]  b_q,
	output fp_word_t            sign_res
);

	fp_word_t fa;
	fp_word_t fb;
	fp_word_t res;
	logic a_zero;
	logic a_nan;

	assign fa = a_q;
	assign fb = b_q;

	// Zero of either sign, NaN of either kind
	assign a_zero = (fa.exp == '0) && (fa.sig == '0);
	assign a_nan = (fa.exp == `FPU_EXP_MAX) && (fa.sig != '0);

	always_comb
	begin
		res = '0;
		case (op_q.flt_func)
			FLT_SGNJ:
			begin
				res = fb;
				res.sign = fa.sign;
			end
			FLT_SGNJN:
			begin
				res = fb;
				res.sign = ~fa.sign;
			end
			FLT_SGNJX:
			begin
				res = fb;
				res.sign = fa.sign ^ fb.sign;
			end
			FLT_SIGN:
			begin
				if (a_zero || a_nan)
					res = fa;  // Passed through as is
				else
				begin
					res = fp_word_t'(`FPU_ONE);
					res.sign = fa.sign;  // +/-1.0
				end
			end
			default:
				res = '0;
		endcase
	end

	always_ff @(posedge clk)
		sign_res <= res;

endmodule

`default_nettype wire

// File: hdl/fpu_issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "fpu_consts.svh"

module fpu_issue_stage import fpu_pkg::*; (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       issue,
	input  opcode_t                   opcode,
	input  r3_func_t                  r3_func,
	input  wire [2:0]                 op3,
	input  flt_func_t                 flt_func,
	input  wire [`FPU_SCALE_WID-1:0]  scale,
	input  wire                       rc,
	input  wire [`FPU_WID-1:0]        a,
	input  wire [`FPU_WID-1:0]        b,
	input  wire [`FPU_WID-1:0]        c,
	input  wire [`FPU_WID-1:0]        t,
	input  wire [`FPU_WID-1:0]        i,
	input  fp_status_t                s,
	output micro_op_t                 op_q,
	output logic [`FPU_WID-1:0]       a_q,
	output logic [`FPU_WID-1:0]       b_q,
	output logic [`FPU_WID-1:0]       c_q,
	output logic [`FPU_WID-1:0]       i_q,
	output micro_op_t                 op_d2,
	output logic [`FPU_WID-1:0]       t_d2,
	output fp_status_t                s_d2
);

	micro_op_t op_d;

	// Pack loose fields; a strobe during reset is dropped
	always_comb
	begin
		op_d.issue = issue & ~rst;
		op_d.opcode = opcode;
		op_d.r3_func = r3_func;
		op_d.op3 = op3;
		op_d.flt_func = flt_func;
		op_d.scale = scale;
		op_d.rc = rc;
		op_d.rm_src = a[`FPU_RM_WID-1:0];
	end

	// Stage 1 for the processing units
	always_ff @(posedge clk)
	begin
		op_q <= op_d;
		a_q <= a;
		b_q <= b;
		c_q <= c;
		i_q <= i;
		if (rst)
			op_q.issue <= 1'b0;
	end

	// ==============================
	// Side band to the result stage
	// ==============================
	delay_pipe #(.payload_t(micro_op_t)) u_op_pipe (.clk(clk), .d(op_d), .q(op_d2));
	delay_pipe #(.payload_t(logic [`FPU_WID-1:0])) u_t_pipe (.clk(clk), .d(t), .q(t_d2));
	delay_pipe #(.payload_t(fp_status_t)) u_s_pipe (.clk(clk), .d(s), .q(s_d2));

	a_opcode_known: assert property (@(posedge clk) disable iff (rst)
		issue |-> !$isunknown({opcode, r3_func, op3, flt_func, scale, rc}));

endmodule

`default_nettype wire

// File: hdl/delay_pipe.sv
`timescale 1ns/1ns
`default_nettype none

// Two register delay for any payload
module delay_pipe #(
	parameter type payload_t = logic
) (
	input  wire      clk,
	input  payload_t d,
	output payload_t q
);

	payload_t stage1;

	always_ff @(posedge clk)
	begin
		stage1 <= d;
		q <= stage1;
	end

endmodule

`default_nettype wire

// File: hdl/fpu_pkg.sv
`default_nettype none

`include "fpu_consts.svh"

package fpu_pkg;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADDI,
		OP_SUBFI,
		OP_ANDI,
		OP_ORI,
		OP_XORI,
		OP_R3,
		OP_FLT,
		OP_LOADA
	} opcode_t;

	// First op of a fused R3 pair
	typedef enum logic [1:0] {FN_ADD, FN_AND, FN_OR, FN_XOR} r3_func_t;

	typedef enum logic [2:0] {FLT_SGNJ, FLT_SGNJN, FLT_SGNJX, FLT_SIGN, FLT_RM} flt_func_t;

	typedef struct packed {
		logic                    sign;
		logic [`FPU_EXP_WID-1:0] exp;
		logic [`FPU_SIG_WID-1:0] sig;
	} fp_word_t;

	typedef struct packed {
		logic [`FPU_RM_WID-1:0] rm;
		logic                   cls;  // Denormal, -0 or quiet NaN
		logic                   neg;
		logic                   pos;
		logic                   zero;
		logic                   inf;
	} fp_status_t;

	// Decoded op word, carried down the pipeline
	typedef struct packed {
		logic                      issue;   // Valid marker
		opcode_t                   opcode;
		r3_func_t                  r3_func;
		logic [2:0]                op3;
		flt_func_t                 flt_func;
		logic [`FPU_SCALE_WID-1:0] scale;
		logic                      rc;
		logic [`FPU_RM_WID-1:0]    rm_src;  // Low bits of a for FRM
	} micro_op_t;

	// Status fields of a float result, rounding mode supplied
	function automatic fp_status_t fp_classify(fp_word_t w, logic [`FPU_RM_WID-1:0] rm);
		fp_status_t st;
		logic mag_zero;
		mag_zero = (w.exp == '0) && (w.sig == '0);
		st.rm = rm;
		st.cls = ((w.exp == '0) && (w.sig != '0))
			|| (w.sign && mag_zero)
			|| ((w.exp == `FPU_EXP_MAX) && w.sig[`FPU_SIG_WID-1]);
		st.neg = w.sign && !mag_zero;
		st.pos = !w.sign && !mag_zero;
		st.zero = mag_zero;
		st.inf = (w.exp == `FPU_EXP_MAX) && (w.sig == '0);
		return st;
	endfunction

endpackage

`default_nettype wire

// File: hdl/fpu_consts.svh
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// Float format, IEEE double
`define FPU_WID         64
`define FPU_EXP_WID     11
`define FPU_SIG_WID     52
`define FPU_EXP_MAX     11'h7FF
`define FPU_ONE         64'h3FF0_0000_0000_0000

// Status and op fields
`define FPU_RM_WID      3
`define FPU_SCALE_WID   2

// Issue to done, in cycles
`define FPU_LATENCY     3

`endif
